// File: Makefile
TOP = tb_cpu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --timescale 1ns/1ns -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: files.f
source/isa_pkg.sv
source/soc_pkg.sv
source/pipe_if.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/mem_wb_unit.sv
source/cpu_top.sv
test/tb_cpu.sv

// File: source/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               run,       // Low while loading
    input  logic                               prog_we,
    input  logic [soc_pkg::IMEM_ADDR_BITS-1:0] prog_addr,
    input  logic [isa_pkg::DATA_BITS-1:0]      prog_data,
    input  logic [isa_pkg::DATA_BITS-1:0]      io_in,
    output logic [isa_pkg::DATA_BITS-1:0]      io_out,
    output logic                               io_valid
);
    import isa_pkg::*;

    inst_t                inst;
    logic [DATA_BITS-1:0] pc_next;
    logic                 valid;
    logic                 stall;
    logic                 redirect;
    logic [DATA_BITS-1:0] target;
    logic                 wb_we;
    logic [REG_BITS-1:0]  wb_dst;
    logic [DATA_BITS-1:0] wb_data;

    dec_ex_if dx ();
    ex_mem_if em ();

    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .inst      (inst),
        .pc_next   (pc_next),
        .valid     (valid)
    );

    decode_unit u_decode (
        .clk      (clk),
        .reset    (reset),
        .inst     (inst),
        .pc_next  (pc_next),
        .valid    (valid),
        .redirect (redirect),
        .wb_we    (wb_we),
        .wb_dst   (wb_dst),
        .wb_data  (wb_data),
        .em       (em.monitor),
        .dx       (dx.source),
        .stall    (stall)
    );

    execute_unit u_execute (
        .clk      (clk),
        .reset    (reset),
        .dx       (dx.sink),
        .em       (em.source),
        .redirect (redirect),
        .target   (target)
    );

    mem_wb_unit u_mem_wb (
        .clk      (clk),
        .reset    (reset),
        .io_in    (io_in),
        .em       (em.sink),
        .wb_we    (wb_we),
        .wb_dst   (wb_dst),
        .wb_data  (wb_data),
        .io_out   (io_out),
        .io_valid (io_valid)
    );

endmodule

`default_nettype wire

// File: source/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  isa_pkg::inst_t                inst,
    input  logic [isa_pkg::DATA_BITS-1:0] pc_next,
    input  logic                          valid,
    input  logic                          redirect,
    input  logic                          wb_we,
    input  logic [isa_pkg::REG_BITS-1:0]  wb_dst,
    input  logic [isa_pkg::DATA_BITS-1:0] wb_data,
    ex_mem_if.monitor                     em,
    dec_ex_if.source                      dx,
    output logic                          stall
);
    import isa_pkg::*;

    logic [DATA_BITS-1:0] regs [REG_COUNT];

    op1_e                 op1;
    logic [REG_BITS-1:0]  rd;
    logic [REG_BITS-1:0]  rs;
    logic [REG_BITS-1:0]  rt;
    logic [IMM_BITS-1:0]  imm;
    logic [DATA_BITS-1:0] rs_val;
    logic [DATA_BITS-1:0] rt_val;

    logic                 reg_we;
    logic                 mem_we;
    logic                 mem_re;
    logic                 uses_rt;
    logic                 dst_rd;
    alu_src_e             alu_src;
    wb_sel_e              wb_sel;
    logic [REG_BITS-1:0]  dst;

    logic                 hazard_rs;
    logic                 hazard_rt;
    logic                 bubble;

    // Register view for opcode and register numbers, immediate view for imm
    assign op1 = inst.r.op1;
    assign rd  = inst.r.rd;
    assign rs  = inst.r.rs;
    assign rt  = inst.r.rt;
    assign imm = inst.i.imm;

    always_comb begin
        reg_we  = 1'b0;
        mem_we  = 1'b0;
        mem_re  = 1'b0;
        uses_rt = 1'b0;
        dst_rd  = 1'b0;
        alu_src = ALU_IMM;
        wb_sel  = WB_ALU;
        case (op1)
            OP1_ALUR: begin
                reg_we  = 1'b1;
                uses_rt = 1'b1;
                dst_rd  = 1'b1;
                alu_src = ALU_REG;
            end
            OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
                uses_rt = 1'b1; // Compare rs with rt
                alu_src = ALU_REG;
            end
            OP1_JAL: begin
                reg_we  = 1'b1;
                alu_src = ALU_IMM4;
                wb_sel  = WB_PC;
            end
            OP1_LW: begin
                reg_we = 1'b1;
                mem_re = 1'b1;
                wb_sel = WB_MEM;
            end
            OP1_SW: begin
                mem_we  = 1'b1;
                uses_rt = 1'b1; // Store data
            end
            OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI:
                reg_we = 1'b1;
            default: ;          // Unknown opcode runs as a no-op
        endcase
    end

    assign dst = dst_rd ? rd : rt;

    always_ff @(posedge clk) begin
        if (wb_we)
            regs[wb_dst] <= wb_data;
    end

    // Same-cycle write-back is forwarded to the read
    assign rs_val = (wb_we && wb_dst == rs) ? wb_data : regs[rs];
    assign rt_val = (wb_we && wb_dst == rt) ? wb_data : regs[rt];

    // RAW against execute and memory stages
    assign hazard_rs = (dx.reg_we && dx.dst == rs) || (em.reg_we && em.dst == rs);
    assign hazard_rt = uses_rt &&
                       ((dx.reg_we && dx.dst == rt) || (em.reg_we && em.dst == rt));
    assign stall     = valid && (hazard_rs || hazard_rt);
    assign bubble    = stall || redirect || !valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dx.op1    <= OP1_ALUR;
            dx.reg_we <= 1'b0;
            dx.mem_we <= 1'b0;
            dx.mem_re <= 1'b0;
        end else begin
            dx.op1    <= bubble ? OP1_ALUR : op1; // Keeps execute from branching
            dx.reg_we <= reg_we && !bubble;
            dx.mem_we <= mem_we && !bubble;
            dx.mem_re <= mem_re && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc      <= pc_next;
        dx.op2     <= inst.r.op2;
        dx.rs_val  <= rs_val;
        dx.rt_val  <= rt_val;
        dx.imm     <= {{(DATA_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm};
        dx.alu_src <= alu_src;
        dx.dst     <= dst;
        dx.wb_sel  <= wb_sel;
    end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic                          clk,
    input  logic                          reset,
    dec_ex_if.sink                        dx,
    ex_mem_if.source                      em,
    output logic                          redirect,
    output logic [isa_pkg::DATA_BITS-1:0] target
);
    import isa_pkg::*;

    logic signed [DATA_BITS-1:0] a;
    logic signed [DATA_BITS-1:0] b;
    logic signed [DATA_BITS-1:0] rt_s;
    logic [DATA_BITS-1:0]        imm4;
    logic [4:0]                  shamt;
    logic [DATA_BITS-1:0]        alu_out;

    assign imm4 = dx.imm << 2;
    assign a    = dx.rs_val;
    assign rt_s = dx.rt_val;

    always_comb begin
        case (dx.alu_src)
            ALU_IMM:  b = dx.imm;
            ALU_IMM4: b = imm4;
            default:  b = dx.rt_val;
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        case (dx.op1)
            OP1_ALUR: begin
                case (dx.op2)
                    OP2_EQ:   alu_out = {{(DATA_BITS-1){1'b0}}, a == b};
                    OP2_LT:   alu_out = {{(DATA_BITS-1){1'b0}}, a < b};  // Signed
                    OP2_LE:   alu_out = {{(DATA_BITS-1){1'b0}}, a <= b};
                    OP2_NE:   alu_out = {{(DATA_BITS-1){1'b0}}, a != b};
                    OP2_ADD:  alu_out = a + b;
                    OP2_AND:  alu_out = a & b;
                    OP2_OR:   alu_out = a | b;
                    OP2_XOR:  alu_out = a ^ b;
                    OP2_SUB:  alu_out = a - b;
                    OP2_NAND: alu_out = ~(a & b);
                    OP2_NOR:  alu_out = ~(a | b);
                    OP2_NXOR: alu_out = ~(a ^ b);
                    OP2_RSHF: alu_out = a >>> shamt; // Arithmetic
                    OP2_LSHF: alu_out = a << shamt;
                    default:  alu_out = '0;
                endcase
            end
            OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + b; // Address or sum
            OP1_ANDI: alu_out = a & b;
            OP1_ORI:  alu_out = a | b;
            OP1_XORI: alu_out = a ^ b;
            default:  alu_out = '0;
        endcase
    end

    // Branch resolution on signed register values
    always_comb begin
        case (dx.op1)
            OP1_BEQ: redirect = a == rt_s;
            OP1_BLT: redirect = a < rt_s;
            OP1_BLE: redirect = a <= rt_s;
            OP1_BNE: redirect = a != rt_s;
            OP1_JAL: redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign target = (dx.op1 == OP1_JAL) ? a + b : dx.pc + imm4; // JAL base plus imm4

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            em.reg_we <= 1'b0;
            em.mem_we <= 1'b0;
            em.mem_re <= 1'b0;
        end else begin
            em.reg_we <= dx.reg_we;
            em.mem_we <= dx.mem_we;
            em.mem_re <= dx.mem_re;
        end
    end

    always_ff @(posedge clk) begin
        em.pc        <= dx.pc;      // Link value for JAL
        em.alu_out   <= alu_out;
        em.store_val <= dx.rt_val;
        em.dst       <= dx.dst;
        em.wb_sel    <= dx.wb_sel;
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                stall,
    input  logic                                redirect,
    input  logic [isa_pkg::DATA_BITS-1:0]       target,
    input  logic                                prog_we,
    input  logic [soc_pkg::IMEM_ADDR_BITS-1:0]  prog_addr,
    input  logic [isa_pkg::DATA_BITS-1:0]       prog_data,
    output isa_pkg::inst_t                      inst,
    output logic [isa_pkg::DATA_BITS-1:0]       pc_next,
    output logic                                valid
);
    import isa_pkg::*;
    import soc_pkg::*;

    logic [DATA_BITS-1:0] imem [IMEM_WORDS];
    logic [DATA_BITS-1:0] pc;
    logic [DATA_BITS-1:0] pc_plus;
    logic [DATA_BITS-1:0] fetch_word;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
    end

    assign fetch_word = imem[pc[IMEM_ADDR_BITS+1:2]]; // Word aligned
    assign pc_plus    = pc + INST_SIZE;

    // Redirect wins over stall and run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= START_PC;
            valid <= 1'b0;
        end else if (redirect) begin
            pc    <= target;
            valid <= 1'b0; // Wrong-path slot
        end else if (!stall) begin
            if (run)
                pc <= pc_plus;
            valid <= run;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            inst    <= inst_t'(fetch_word);
            pc_next <= pc_plus;
        end
    end

endmodule

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int DATA_BITS = 32;
    localparam int REG_BITS  = 4;
    localparam int REG_COUNT = 16;
    localparam int IMM_BITS  = 16;
    localparam logic [DATA_BITS-1:0] INST_SIZE = 32'd4; // PC step per instruction

    // Primary opcode
    typedef enum logic [5:0] {
        OP1_ALUR = 6'b000000,
        OP1_BEQ  = 6'b001000,
        OP1_BLT  = 6'b001001,
        OP1_BLE  = 6'b001010,
        OP1_BNE  = 6'b001011,
        OP1_JAL  = 6'b001100,
        OP1_LW   = 6'b010010,
        OP1_SW   = 6'b011010,
        OP1_ADDI = 6'b100000,
        OP1_ANDI = 6'b100100,
        OP1_ORI  = 6'b100101,
        OP1_XORI = 6'b100110
    } op1_e;

    // Secondary opcode used only under ALUR
    typedef enum logic [7:0] {
        OP2_EQ   = 8'b00001000,
        OP2_LT   = 8'b00001001,
        OP2_LE   = 8'b00001010,
        OP2_NE   = 8'b00001011,
        OP2_ADD  = 8'b00100000,
        OP2_AND  = 8'b00100100,
        OP2_OR   = 8'b00100101,
        OP2_XOR  = 8'b00100110,
        OP2_SUB  = 8'b00101000,
        OP2_NAND = 8'b00101100,
        OP2_NOR  = 8'b00101101,
        OP2_NXOR = 8'b00101110,
        OP2_RSHF = 8'b00110000,
        OP2_LSHF = 8'b00110001
    } op2_e;

    typedef enum logic [1:0] {
        WB_PC  = 2'd0, // Link address
        WB_MEM = 2'd1,
        WB_ALU = 2'd2
    } wb_sel_e;

    // Second ALU operand source
    typedef enum logic [1:0] {
        ALU_REG  = 2'd0,
        ALU_IMM  = 2'd1,
        ALU_IMM4 = 2'd2
    } alu_src_e;

    typedef union packed {
        struct packed {
            op1_e                op1;
            op2_e                op2;
            logic [5:0]          spare;
            logic [REG_BITS-1:0] rd;
            logic [REG_BITS-1:0] rs;
            logic [REG_BITS-1:0] rt;
        } r;
        struct packed {
            op1_e                op1;
            logic [1:0]          spare;
            logic [IMM_BITS-1:0] imm;
            logic [REG_BITS-1:0] rs;
            logic [REG_BITS-1:0] rt;
        } i;
    } inst_t;

endpackage

`default_nettype wire

// File: source/mem_wb_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [isa_pkg::DATA_BITS-1:0] io_in,
    ex_mem_if.sink                        em,
    output logic                          wb_we,
    output logic [isa_pkg::REG_BITS-1:0]  wb_dst,
    output logic [isa_pkg::DATA_BITS-1:0] wb_data,
    output logic [isa_pkg::DATA_BITS-1:0] io_out,
    output logic                          io_valid
);
    import isa_pkg::*;
    import soc_pkg::*;

    logic [DATA_BITS-1:0]          dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] dmem_idx;
    logic                          out_hit;
    logic                          in_hit;
    logic [DATA_BITS-1:0]          load_val;

    logic [DATA_BITS-1:0]          pc_wb;
    logic [DATA_BITS-1:0]          alu_wb;
    logic [DATA_BITS-1:0]          load_wb;
    wb_sel_e                       wb_sel_wb;

    assign dmem_idx = em.alu_out[$clog2(DMEM_WORDS)+1:2];
    assign out_hit  = em.alu_out == ADDR_OUT;
    assign in_hit   = em.alu_out == ADDR_IN;

    always_ff @(posedge clk) begin
        if (em.mem_we && !out_hit)
            dmem[dmem_idx] <= em.store_val;
    end

    assign load_val = !em.mem_re ? '0 :
                      in_hit     ? io_in :
                                   dmem[dmem_idx];

    // Output register with a one-cycle strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            io_out   <= OUT_RESET;
            io_valid <= 1'b0;
        end else begin
            if (em.mem_we && out_hit)
                io_out <= em.store_val;
            io_valid <= em.mem_we && out_hit;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            wb_we <= 1'b0;
        else
            wb_we <= em.reg_we;
    end

    always_ff @(posedge clk) begin
        wb_dst    <= em.dst;
        pc_wb     <= em.pc;
        alu_wb    <= em.alu_out;
        load_wb   <= load_val;
        wb_sel_wb <= em.wb_sel;
    end

    always_comb begin
        case (wb_sel_wb)
            WB_PC:   wb_data = pc_wb;
            WB_MEM:  wb_data = load_wb;
            default: wb_data = alu_wb;
        endcase
    end

endmodule

`default_nettype wire

// File: source/pipe_if.sv
`timescale 1ns/1ns
`default_nettype none

// Decode to execute pipeline register
interface dec_ex_if;
    import isa_pkg::*;

    logic [DATA_BITS-1:0] pc;      // Instruction address plus 4
    op1_e                 op1;
    op2_e                 op2;
    logic [DATA_BITS-1:0] rs_val;
    logic [DATA_BITS-1:0] rt_val;
    logic [DATA_BITS-1:0] imm;     // Sign-extended
    alu_src_e             alu_src;
    logic [REG_BITS-1:0]  dst;
    logic                 reg_we;
    logic                 mem_we;
    logic                 mem_re;
    wb_sel_e              wb_sel;

    modport source (output pc, op1, op2, rs_val, rt_val, imm, alu_src,
                    dst, reg_we, mem_we, mem_re, wb_sel);
    modport sink   (input pc, op1, op2, rs_val, rt_val, imm, alu_src,
                    dst, reg_we, mem_we, mem_re, wb_sel);
endinterface

// Execute to memory pipeline register
interface ex_mem_if;
    import isa_pkg::*;

    logic [DATA_BITS-1:0] pc;
    logic [DATA_BITS-1:0] alu_out;   // Also the data address
    logic [DATA_BITS-1:0] store_val;
    logic [REG_BITS-1:0]  dst;
    logic                 reg_we;
    logic                 mem_we;
    logic                 mem_re;
    wb_sel_e              wb_sel;

    modport source  (output pc, alu_out, store_val, dst, reg_we, mem_we, mem_re, wb_sel);
    modport sink    (input pc, alu_out, store_val, dst, reg_we, mem_we, mem_re, wb_sel);
    modport monitor (input dst, reg_we); // Hazard check in decode
endinterface

`default_nettype wire

// File: source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int IMEM_WORDS     = 16384;
    localparam int DMEM_WORDS     = 16384;
    localparam int IMEM_ADDR_BITS = 14; // Word address into instruction memory

    localparam logic [31:0] START_PC  = 32'h0000_0100;
    localparam logic [31:0] ADDR_OUT  = 32'hFFFF_F000; // Output register
    localparam logic [31:0] ADDR_IN   = 32'hFFFF_F080; // Input word
    localparam logic [31:0] OUT_RESET = 32'h00FE_DEAD;

endpackage

`default_nettype wire

// File: test/cpu_stim.txt
// Hex words read in order: io_in value, program length, expected output count,
// then the program words from 0x100 on, then the expected io_out values in order
5A3C96E1 00000043 0000001A
// Immediate forms, dependent chain r1 -> r3 -> r4 -> r5 with no spacing
90000000 80123401 68F00001 80FFFD02
9000F013 940F0034 98FFFF45 68F00003
68F00004 68F00005 80002407
// ALUR EQ LT LE NE into r6, each stored to the output register
00200611 68F00006 00240612 68F00006 00280621 68F00006 002C0612 68F00006
// ALUR ADD AND OR XOR
00800612 68F00006 00900612 68F00006 00940612 68F00006 00980612 68F00006
// ALUR SUB NAND NOR NXOR
00A00612 68F00006 00B00612 68F00006 00B40612 68F00006 00B80612 68F00006
// ALUR RSHF LSHF by r7 = 0x24, low five bits give 4
00C00657 68F00006 00C40617 68F00006
// BEQ not taken, both slots store
80005508 20000212 68F00008 68F00003
// BNE taken, BLT taken, slots skipped
2C000212 68F00005 68F00005
24000221 68F00005 68F00005
// BLE not taken
28000212 68F00008 68F00004
// JAL at 0x1D0 to 0x1DC, link in r10
3000770A 68F00005 68F00005 68F0000A
// Data memory round trip, then the input word
68004005 68004401 4800400C 68F0000C 4800440C 68F0000C
48F0800D 68F0000D
// Self loop and fill for the fetched slots behind it
20FFFF00 90000000 90000000
// Expected io_out values
00001234 00000030 00000F30 FFFFF0CF
00000001 00000000 00000001 00000001
00001231 00001234 FFFFFFFD FFFFEDC9
00001237 FFFFEDCB 00000002 00001236
FFFFFF0C 00012340
00000055 00000030 00000055 00000F30
000001D4
FFFFF0CF 00001234 5A3C96E1

// File: test/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
    import isa_pkg::*;
    import soc_pkg::*;

    localparam int STIM_WORDS   = 256;
    localparam int HEAD_WORDS   = 3;    // io_in, program length, output count
    localparam int WAIT_CYCLES  = 2000;
    localparam int QUIET_CYCLES = 100;

    logic                      clk;
    logic                      reset;
    logic                      run;
    logic                      prog_we;
    logic [IMEM_ADDR_BITS-1:0] prog_addr;
    logic [DATA_BITS-1:0]      prog_data;
    logic [DATA_BITS-1:0]      io_in;
    logic [DATA_BITS-1:0]      io_out;
    logic                      io_valid;

    logic [31:0] stim [STIM_WORDS];
    int          prog_len;
    int          exp_len;
    int          exp_base;
    int          errors;
    int          checks;
    int          out_errors = 0; // Owned by the output monitor
    int          out_checks = 0;
    int          seen = 0;

    cpu_top dut (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .io_in     (io_in),
        .io_out    (io_out),
        .io_valid  (io_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each strobe is compared in order with the expected list
    always @(negedge clk) begin
        if (!reset && io_valid) begin
            out_checks++;
            if (!run) begin
                $display("FAIL io_valid: got %h while run is low, expected 0", io_valid);
                out_errors++;
            end else if (seen >= exp_len) begin
                $display("Extra output %0d after the expected list, io_out = %h",
                         seen + 1, io_out);
                out_errors++;
            end else if (io_out !== stim[exp_base + seen]) begin
                $display("FAIL io_out: got %h, expected %h (output %0d)",
                         io_out, stim[exp_base + seen], seen + 1);
                out_errors++;
            end
            if (run)
                seen++;
        end
    end

    // Program words go to consecutive words from the start address
    task automatic load_program();
        int          i;
        logic [31:0] word_addr;
        for (i = 0; i < prog_len; i++) begin
            @(posedge clk);
            word_addr = (START_PC >> 2) + i;
            prog_we   <= 1'b1;
            prog_addr <= word_addr[IMEM_ADDR_BITS-1:0];
            prog_data <= stim[HEAD_WORDS + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Core held with run low
    task automatic check_held_state();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            checks++;
            if (io_out !== OUT_RESET) begin
                $display("FAIL io_out: got %h, expected %h", io_out, OUT_RESET);
                errors++;
            end
            if (io_valid !== 1'b0) begin
                $display("FAIL io_valid: got %h, expected 0", io_valid);
                errors++;
            end
        end
    endtask

    task automatic wait_for_outputs();
        int cycles;
        cycles = 0;
        while (seen < exp_len && cycles < WAIT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (seen < exp_len) begin
            $display("Timed out after %0d cycles with %0d of %0d outputs seen",
                     cycles, seen, exp_len);
            errors++;
        end
    endtask

    // Any strobe in this window is flagged by the monitor
    task automatic watch_quiet_window();
        int cycles;
        for (cycles = 0; cycles < QUIET_CYCLES; cycles++)
            @(posedge clk);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        io_in     = '0;
        $readmemh("test/cpu_stim.txt", stim);
        prog_len = stim[1];
        exp_len  = stim[2];
        exp_base = HEAD_WORDS + prog_len;
        if (prog_len == 0 || exp_len == 0 || exp_base + exp_len > STIM_WORDS) begin
            $display("Stimulus file is missing or its counts do not fit the buffer");
            errors++;
            prog_len = 0;
            exp_len  = 0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        io_in <= stim[0];
        load_program();
        check_held_state();
        @(posedge clk);
        run <= 1'b1;
        wait_for_outputs();
        watch_quiet_window();
        $display("Checks: %0d, outputs: %0d of %0d, errors: %0d",
                 checks + out_checks, seen, exp_len, errors + out_errors);
        if (errors + out_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
